// ==== source/trace_pkg.sv ====
// ============================================================================
// trace capture package
// widths, state and command encodings, and the packed records shared by
// the trace front end blocks
// ============================================================================
`default_nettype none

package trace_pkg;

  localparam int buffer_bytes   = 8;
  localparam int buffer_width   = buffer_bytes * 8;
  localparam int match_rules    = 4;
  localparam int rule_idx_width = 2;
  localparam int stamp_width    = 6;
  localparam int stamp_max      = 63;   // stamp saturates here
  localparam int hit_width      = 8;
  localparam int len_width      = 16;
  localparam int trig_cnt_width = 4;

  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_armed     = 2'd1,
    st_capturing = 2'd2,
    st_done      = 2'd3
  } capture_state_e;

  // command field of a fifo word
  typedef enum logic [1:0] {
    fe_data  = 2'b00,   // plain captured byte
    fe_match = 2'b01    // byte that completed a rule match
  } fe_cmd_e;

  typedef struct packed {
    logic [buffer_width-1:0] pattern;
    logic [buffer_width-1:0] mask;
    logic                    enable;
  } match_rule_t;

  typedef struct packed {
    logic [len_width-1:0]      capture_len;   // words per capture, at least 1
    logic [trig_cnt_width-1:0] num_triggers;
    logic                      trigger_enable;
    logic                      capture_raw;   // also write non-matching bytes
  } capture_cfg_t;

  typedef struct packed {
    logic                      valid;
    logic                      hit;
    logic [rule_idx_width-1:0] rule;   // lowest matching rule
    logic [7:0]                data;
  } match_result_t;

  typedef struct packed {
    fe_cmd_e                   cmd;
    logic [rule_idx_width-1:0] rule;
    logic [stamp_width-1:0]    stamp;
    logic [7:0]                data;
  } fifo_word_t;

endpackage

`default_nettype wire

// ==== source/trace_shift_buffer.sv ====
// ============================================================================
// trace shift buffer
// keeps the last eight trace bytes, newest in the low byte, and flags the
// cycle after each shift for the matcher
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module trace_shift_buffer (
  input  logic                               fe_clk,
  input  logic                               reset,
  input  logic                               arm,
  input  logic [7:0]                         trace_byte,
  input  logic                               trace_valid,
  output logic [trace_pkg::buffer_width-1:0] buffer,
  output logic                               buffer_valid
);

  import trace_pkg::*;

  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      buffer       <= '0;   // arm restarts the history
      buffer_valid <= 1'b0;
    end else begin
      buffer_valid <= trace_valid;
      if (trace_valid) begin
        buffer <= {buffer[buffer_width-9:0], trace_byte};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pattern_matcher.sv ====
// ============================================================================
// pattern matcher
// masked compare of the trace buffer against every rule in parallel,
// registers the lowest hitting rule with the newest byte, and keeps a
// saturating hit count per rule
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher (
  input  logic                               fe_clk,
  input  logic                               reset,
  input  logic                               arm,
  input  logic [trace_pkg::buffer_width-1:0] buffer,
  input  logic                               buffer_valid,
  input  trace_pkg::match_rule_t             rules [trace_pkg::match_rules],
  input  logic                               count_enable,
  output trace_pkg::match_result_t           result,
  output logic [trace_pkg::hit_width-1:0]    rule_hits [trace_pkg::match_rules]
);

  import trace_pkg::*;

  logic [match_rules-1:0]    hit_vec;
  logic [rule_idx_width-1:0] low_rule;

  logic                      res_valid;
  logic                      res_hit;
  logic [rule_idx_width-1:0] res_rule;
  logic [7:0]                res_data;

  // walk down so the lowest index wins
  always_comb begin
    hit_vec  = '0;
    low_rule = '0;
    for (int i = match_rules - 1; i >= 0; i--) begin
      hit_vec[i] = rules[i].enable &&
                   ((buffer & rules[i].mask) == (rules[i].pattern & rules[i].mask));
      if (hit_vec[i]) begin
        low_rule = rule_idx_width'(i);
      end
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      res_valid <= 1'b0;   // drops results in flight
    end else begin
      res_valid <= buffer_valid;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (buffer_valid) begin
      res_hit  <= |hit_vec;
      res_rule <= low_rule;
      res_data <= buffer[7:0];   // byte just shifted in
    end
  end

  assign result = '{valid: res_valid, hit: res_hit, rule: res_rule, data: res_data};

  // every hitting rule counts, not only the lowest
  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      for (int i = 0; i < match_rules; i++) begin
        rule_hits[i] <= '0;
      end
    end else if (buffer_valid && count_enable) begin
      for (int i = 0; i < match_rules; i++) begin
        if (hit_vec[i] && (rule_hits[i] != {hit_width{1'b1}})) begin
          rule_hits[i] <= rule_hits[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/capture_counters.sv ====
// ============================================================================
// capture counters
// saturating timestamp since the last written word, and the count of
// written words against the configured capture length
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module capture_counters (
  input  logic                              fe_clk,
  input  logic                              reset,
  input  logic                              start,
  input  logic                              write,
  input  logic [trace_pkg::len_width-1:0]   capture_len,
  output logic [trace_pkg::stamp_width-1:0] stamp,
  output logic                              last_word
);

  import trace_pkg::*;

  logic [len_width-1:0] word_cnt;

  // stamp reads as the cycle distance to the previous write
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      stamp <= '0;
    end else if (write) begin
      stamp <= stamp_width'(1);
    end else if (stamp != stamp_width'(stamp_max)) begin
      stamp <= stamp + 1'b1;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset || start) begin
      word_cnt <= '0;
    end else if (write) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // next write completes the capture
  assign last_word = (word_cnt == (capture_len - len_width'(1)));

endmodule

`default_nettype wire

// ==== source/capture_fsm.sv ====
// ============================================================================
// capture FSM
// idle, armed, capturing and done sequencing; picks the matcher results that
// become fifo words, packs and writes them, and flags dropped words
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module capture_fsm (
  input  logic                              fe_clk,
  input  logic                              reset,
  input  logic                              arm,
  input  trace_pkg::match_result_t          result,
  input  logic                              capture_raw,
  input  logic                              fifo_full,
  input  logic [trace_pkg::stamp_width-1:0] stamp,
  input  logic                              last_word,
  output trace_pkg::capture_state_e         state,
  output logic                              start,
  output logic                              write,
  output trace_pkg::fifo_word_t             fifo_word,
  output logic                              fifo_wr,
  output logic                              capture_done,
  output logic                              overflow
);

  import trace_pkg::*;

  capture_state_e cur;   // decision state, one cycle ahead of state
  logic           due;
  fe_cmd_e        word_cmd;

  always_comb begin
    due = 1'b0;
    if (result.valid && !arm) begin
      case (cur)
        st_armed:     due = result.hit;
        st_capturing: due = result.hit || capture_raw;
        default:      due = 1'b0;
      endcase
    end
  end

  assign write = due && !fifo_full;   // full fifo drops the word

  always_comb begin
    word_cmd = fe_data;
    if (result.hit) begin
      word_cmd = fe_match;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      cur <= st_idle;
    end else if (arm) begin
      cur <= st_armed;
    end else if (write) begin
      if (last_word) begin
        cur <= st_done;
      end else if (cur == st_armed) begin
        cur <= st_capturing;   // trigger word
      end
    end
  end

  // visible state follows the write that caused it
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state <= st_idle;
    end else if (arm) begin
      state <= st_armed;
    end else begin
      state <= cur;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      start   <= 1'b0;
      fifo_wr <= 1'b0;
    end else begin
      start   <= arm;
      fifo_wr <= write;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (write) begin
      fifo_word.cmd   <= word_cmd;
      fifo_word.rule  <= result.rule;
      fifo_word.stamp <= (cur == st_armed) ? '0 : stamp;   // trigger has stamp 0
      fifo_word.data  <= result.data;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      overflow <= 1'b0;
    end else if (due && fifo_full) begin
      overflow <= 1'b1;   // sticky until next arm
    end
  end

  assign capture_done = (state == st_done);

endmodule

`default_nettype wire

// ==== source/trigger_pulser.sv ====
// ============================================================================
// trigger pulser
// one registered trig_out pulse per qualifying hit, up to num_triggers
// pulses after each arm
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module trigger_pulser (
  input  logic                                 fe_clk,
  input  logic                                 reset,
  input  logic                                 arm,
  input  trace_pkg::match_result_t             result,
  input  trace_pkg::capture_state_e            state,
  input  logic                                 trigger_enable,
  input  logic [trace_pkg::trig_cnt_width-1:0] num_triggers,
  output logic                                 trig_out
);

  import trace_pkg::*;

  logic [trig_cnt_width-1:0] trig_cnt;   // pulses since arm
  logic                      fire;

  assign fire = result.valid && result.hit && !arm && trigger_enable &&
                ((state == st_armed) || (state == st_capturing)) &&
                (trig_cnt < num_triggers);

  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      trig_cnt <= '0;
      trig_out <= 1'b0;
    end else begin
      trig_out <= fire;
      if (fire) begin
        trig_cnt <= trig_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/trace_capture_top.sv ====
// ============================================================================
// trace capture top
// trace front end: shift buffer, pattern matcher, capture FSM with its
// counters, and the trigger pulser, all on fe_clk
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module trace_capture_top (
  input  logic                            fe_clk,
  input  logic                            reset,
  input  logic [7:0]                      trace_byte,
  input  logic                            trace_valid,
  input  logic                            arm,
  input  trace_pkg::capture_cfg_t         cfg,
  input  trace_pkg::match_rule_t          rules [trace_pkg::match_rules],
  input  logic                            fifo_full,
  output trace_pkg::fifo_word_t           fifo_word,
  output logic                            fifo_wr,
  output logic                            trig_out,
  output trace_pkg::capture_state_e       state,
  output logic                            capture_done,
  output logic                            overflow,
  output logic [trace_pkg::hit_width-1:0] rule_hits [trace_pkg::match_rules]
);

  import trace_pkg::*;

  logic [buffer_width-1:0] buffer;
  logic                    buffer_valid;
  match_result_t           result;
  logic                    count_enable;
  logic                    start;
  logic                    write;
  logic [stamp_width-1:0]  stamp;
  logic                    last_word;

  assign count_enable = (state == st_armed) || (state == st_capturing);

  trace_shift_buffer u_trace_shift_buffer (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .arm          (arm),
    .trace_byte   (trace_byte),
    .trace_valid  (trace_valid),
    .buffer       (buffer),
    .buffer_valid (buffer_valid)
  );

  pattern_matcher u_pattern_matcher (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .arm          (arm),
    .buffer       (buffer),
    .buffer_valid (buffer_valid),
    .rules        (rules),
    .count_enable (count_enable),
    .result       (result),
    .rule_hits    (rule_hits)
  );

  capture_fsm u_capture_fsm (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .arm          (arm),
    .result       (result),
    .capture_raw  (cfg.capture_raw),
    .fifo_full    (fifo_full),
    .stamp        (stamp),
    .last_word    (last_word),
    .state        (state),
    .start        (start),
    .write        (write),
    .fifo_word    (fifo_word),
    .fifo_wr      (fifo_wr),
    .capture_done (capture_done),
    .overflow     (overflow)
  );

  capture_counters u_capture_counters (
    .fe_clk      (fe_clk),
    .reset       (reset),
    .start       (start),
    .write       (write),
    .capture_len (cfg.capture_len),
    .stamp       (stamp),
    .last_word   (last_word)
  );

  trigger_pulser u_trigger_pulser (
    .fe_clk         (fe_clk),
    .reset          (reset),
    .arm            (arm),
    .result         (result),
    .state          (state),
    .trigger_enable (cfg.trigger_enable),
    .num_triggers   (cfg.num_triggers),
    .trig_out       (trig_out)
  );

endmodule

`default_nettype wire

// ==== tests/trace_capture_checker.sv ====
// ============================================================================
// trace capture checker
// protocol assertions on the trace capture top level, bound in from outside
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module trace_capture_checker (
  input logic                      fe_clk,
  input logic                      reset,
  input trace_pkg::capture_state_e state,
  input logic                      fifo_wr,
  input logic                      trig_out
);

  import trace_pkg::*;

  a_reset_quiet: assert property (@(posedge fe_clk)
    reset |=> ((state == st_idle) && !fifo_wr))
    else $error("state or fifo_wr not cleared by reset");

  // triggers only once armed
  a_no_trig_idle: assert property (@(posedge fe_clk) disable iff (reset)
    trig_out |-> (state != st_idle))
    else $error("trig_out pulsed in st_idle");

  a_wr_when_active: assert property (@(posedge fe_clk) disable iff (reset)
    fifo_wr |-> (state inside {st_armed, st_capturing}))
    else $error("fifo_wr in st_idle or st_done");

endmodule

bind trace_capture_top trace_capture_checker u_trace_capture_checker (
  .fe_clk   (fe_clk),
  .reset    (reset),
  .state    (state),
  .fifo_wr  (fifo_wr),
  .trig_out (trig_out)
);

`default_nettype wire

// ==== tests/tb_trace_capture.sv ====
// ============================================================================
// trace capture testbench
// directed tests of the trace front end against an in-order reference
// model, with word, state, flag, count and hit compares and a watchdog
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_trace_capture;

  import trace_pkg::*;

  localparam int clk_period  = 100;
  localparam int test_cycles = 40 + 40 + 120 + 60 + 60 + 50;   // per test, in order
  localparam int run_cycles  = 8 + test_cycles + 200;

  logic                 fe_clk;
  logic                 reset;
  logic [7:0]           trace_byte;
  logic                 trace_valid;
  logic                 arm;
  capture_cfg_t         cfg;
  match_rule_t          rules [match_rules];
  logic                 fifo_full;
  fifo_word_t           fifo_word;
  logic                 fifo_wr;
  logic                 trig_out;
  capture_state_e       state;
  logic                 capture_done;
  logic                 overflow;
  logic [hit_width-1:0] rule_hits [match_rules];

  // reference model, advanced once per strobed byte
  logic [buffer_width-1:0] m_buf;
  capture_state_e          m_state;
  capture_cfg_t            m_cfg;
  logic [hit_width-1:0]    m_hits [match_rules];
  logic                    m_full;
  logic                    m_overflow;
  int                      m_count;
  int                      m_trig;
  int                      m_last_wr;   // strobe cycle of last written byte
  int                      exp_pulses;
  fifo_word_t              exp_words [$];

  fifo_word_t got_words [$];
  int         got_pulses = 0;
  int         got_base;
  int         pulse_base;
  int         cyc;
  string      test_name;

  trace_capture_top u_trace_capture_top (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .trace_byte   (trace_byte),
    .trace_valid  (trace_valid),
    .arm          (arm),
    .cfg          (cfg),
    .rules        (rules),
    .fifo_full    (fifo_full),
    .fifo_word    (fifo_word),
    .fifo_wr      (fifo_wr),
    .trig_out     (trig_out),
    .state        (state),
    .capture_done (capture_done),
    .overflow     (overflow),
    .rule_hits    (rule_hits)
  );

  initial begin
    fe_clk = 1'b0;
    forever #(clk_period / 2) fe_clk = ~fe_clk;
  end

  // outputs sampled midway between driving edges
  always @(negedge fe_clk) begin
    if (fifo_wr) begin
      got_words.push_back(fifo_word);
    end
    if (trig_out) begin
      got_pulses++;
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  initial begin
    #(run_cycles * clk_period);
    abort_run($sformatf("watchdog expired after %0d cycles, tests did not finish", run_cycles));
  end

  task automatic check_word(input string what, input fifo_word_t exp, input fifo_word_t act);
    string exp_text;
    string act_text;
    if (act !== exp) begin
      exp_text = $sformatf("cmd %0d rule %0d stamp %0d data %02h",
                           exp.cmd, exp.rule, exp.stamp, exp.data);
      act_text = $sformatf("cmd %0d rule %0d stamp %0d data %02h",
                           act.cmd, act.rule, act.stamp, act.data);
      abort_run($sformatf("ERR %s %s: expected %s actual %s",
                          test_name, what, exp_text, act_text));
    end
  endtask

  task automatic check_state(input string what, input capture_state_e exp,
                             input capture_state_e act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s %s: expected %s actual %s",
                          test_name, what, exp.name(), act.name()));
    end
  endtask

  task automatic check_hits(input string what, input logic [hit_width-1:0] exp,
                            input logic [hit_width-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s %s: expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act));
    end
  endtask

  function automatic logic rule_hit(input int i);
    return rules[i].enable &&
           ((m_buf & rules[i].mask) == (rules[i].pattern & rules[i].mask));
  endfunction

  task automatic model_byte(input logic [7:0] b);
    logic                      hit;
    logic [rule_idx_width-1:0] rule;
    logic                      active;
    logic                      due;
    int                        gap;
    fifo_word_t                w;
    m_buf  = {m_buf[buffer_width-9:0], b};
    hit    = 1'b0;
    rule   = '0;
    active = (m_state == st_armed) || (m_state == st_capturing);
    for (int i = 0; i < match_rules; i++) begin
      if (rule_hit(i)) begin
        if (!hit) begin
          rule = rule_idx_width'(i);
        end
        hit = 1'b1;
        if (active && (m_hits[i] != 8'hff)) begin
          m_hits[i] = m_hits[i] + 8'd1;
        end
      end
    end
    if (hit && active && m_cfg.trigger_enable && (m_trig < int'(m_cfg.num_triggers))) begin
      m_trig++;
      exp_pulses++;
    end
    due = (m_state == st_armed) ? hit :
          ((m_state == st_capturing) && (hit || m_cfg.capture_raw));
    if (due && m_full) begin
      m_overflow = 1'b1;   // dropped, not counted
    end else if (due) begin
      gap     = cyc - m_last_wr;
      w.cmd   = hit ? fe_match : fe_data;
      w.rule  = rule;
      w.stamp = (m_state == st_armed) ? '0 :
                stamp_width'((gap > stamp_max) ? stamp_max : gap);
      w.data  = b;
      exp_words.push_back(w);
      m_last_wr = cyc;
      m_count++;
      if (m_count == int'(m_cfg.capture_len)) begin
        m_state = st_done;
      end else if (m_state == st_armed) begin
        m_state = st_capturing;
      end
    end
  endtask

  task automatic model_arm();
    m_buf      = '0;
    m_trig     = 0;
    m_count    = 0;
    m_overflow = 1'b0;
    m_state    = st_armed;
    for (int i = 0; i < match_rules; i++) begin
      m_hits[i] = '0;
    end
  endtask

  // every tick drops the one-cycle strobes unless the caller drives them again
  task automatic tick();
    @(posedge fe_clk);
    cyc++;
    trace_valid <= 1'b0;
    arm         <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic settle();
    @(negedge fe_clk);
  endtask

  task automatic send_byte(input logic [7:0] b, input int gap);
    tick();
    trace_byte  <= b;
    trace_valid <= 1'b1;
    model_byte(b);
    repeat (gap - 1) tick();
  endtask

  // 8'h40..8'h7f, no rule can hit on these
  task automatic filler(input int n, input int gap);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = 8'h40 | 8'($urandom() & 32'h3f);
      send_byte(b, gap);
    end
  endtask

  task automatic arm_pulse();
    tick();
    arm <= 1'b1;
    model_arm();
    tick();
  endtask

  task automatic set_cfg(input logic [len_width-1:0] len, input logic [trig_cnt_width-1:0] ntrig,
                         input logic ten, input logic raw);
    tick();
    m_cfg.capture_len    = len;
    m_cfg.num_triggers   = ntrig;
    m_cfg.trigger_enable = ten;
    m_cfg.capture_raw    = raw;
    cfg <= m_cfg;
  endtask

  task automatic set_full(input logic v);
    idle(4);   // let bytes in flight reach their decision first
    fifo_full <= v;
    m_full = v;
  endtask

  task automatic drain_and_compare();
    idle(6);
    settle();
    check_count("word count", exp_words.size(), got_words.size() - got_base);
    foreach (exp_words[i]) begin
      check_word($sformatf("word %0d", i), exp_words[i], got_words[got_base + i]);
    end
    check_count("trigger pulses", exp_pulses, got_pulses - pulse_base);
    check_state("state", m_state, state);
    check_flag("capture_done", m_state == st_done, capture_done);
    check_flag("overflow", m_overflow, overflow);
    for (int i = 0; i < match_rules; i++) begin
      check_hits($sformatf("hits rule %0d", i), m_hits[i], rule_hits[i]);
    end
    got_base   = got_words.size();
    pulse_base = got_pulses;
    exp_pulses = 0;
    exp_words.delete();
  endtask

  task automatic reset_then_arm();
    test_name = "reset_then_arm";
    settle();
    check_state("state after reset", st_idle, state);
    check_flag("fifo_wr after reset", 1'b0, fifo_wr);
    check_flag("trig_out after reset", 1'b0, trig_out);
    set_cfg(16'd4, 4'd3, 1'b1, 1'b1);
    arm_pulse();
    settle();
    check_state("state after arm", st_armed, state);
    filler(16, 1);
    drain_and_compare();
  endtask

  task automatic raw_capture();
    test_name = "raw_capture";
    set_cfg(16'd5, 4'd0, 1'b0, 1'b1);
    arm_pulse();
    filler(3, 2);
    send_byte(8'h11, 2);
    send_byte(8'h22, 2);
    send_byte(8'he3, 2);   // completes rule 2, rule 3 hits as well
    filler(6, 2);
    drain_and_compare();
    check_state("state after capture_len words", st_done, state);
  endtask

  task automatic match_only_capture();
    test_name = "match_only_capture";
    set_cfg(16'd4, 4'd0, 1'b0, 1'b0);
    arm_pulse();
    filler(2, 3);
    send_byte(8'he1, 3);
    filler(1, 2);          // next hit 5 cycles on
    send_byte(8'he2, 9);
    filler(1, 8);          // 17 cycles
    send_byte(8'he4, 40);
    filler(1, 30);         // 70 cycles, stamp saturates
    send_byte(8'he8, 2);
    drain_and_compare();
    check_state("state after four hits", st_done, state);
  endtask

  task automatic send_three_hits();
    send_byte(8'he5, 4);
    filler(2, 2);
    send_byte(8'he6, 4);
    send_byte(8'ha5, 1);
    send_byte(8'hc3, 4);   // rule 0
  endtask

  task automatic trigger_limit();
    int base;
    test_name = "trigger_limit";
    set_cfg(16'd8, 4'd2, 1'b1, 1'b0);
    arm_pulse();
    base = got_pulses;
    send_three_hits();
    drain_and_compare();
    check_count("pulses with limit 2", 2, got_pulses - base);
    set_cfg(16'd8, 4'd2, 1'b0, 1'b0);
    arm_pulse();
    base = got_pulses;
    send_three_hits();
    drain_and_compare();
    check_count("pulses with trigger disabled", 0, got_pulses - base);
  endtask

  task automatic back_pressure();
    test_name = "back_pressure";
    set_cfg(16'd4, 4'd0, 1'b0, 1'b1);
    arm_pulse();
    filler(2, 2);
    send_byte(8'h11, 2);
    send_byte(8'h22, 2);
    send_byte(8'he3, 2);
    filler(1, 2);
    set_full(1'b1);
    filler(3, 2);          // due but dropped
    set_full(1'b0);
    filler(4, 2);
    drain_and_compare();
    check_flag("overflow after drops", 1'b1, overflow);
    check_state("state after four written words", st_done, state);
    arm_pulse();
    settle();
    check_flag("overflow after new arm", 1'b0, overflow);
  endtask

  task automatic hit_counting();
    test_name = "hit_counting";
    set_cfg(16'd100, 4'd0, 1'b0, 1'b0);
    arm_pulse();
    repeat (3) begin
      send_byte(8'he7, 2);
      filler(1, 2);
    end
    send_byte(8'h5a, 2);   // pattern of rule 1, which is disabled
    repeat (2) begin
      send_byte(8'ha5, 1);
      send_byte(8'hc3, 2);
    end
    send_byte(8'h11, 1);
    send_byte(8'h22, 1);
    send_byte(8'he3, 3);
    filler(3, 1);
    drain_and_compare();
    check_hits("rule 0 count", 8'd2, rule_hits[0]);
    check_hits("rule 1 count", 8'd0, rule_hits[1]);   // disabled
    check_hits("rule 2 count", 8'd1, rule_hits[2]);
    check_hits("rule 3 count", 8'd4, rule_hits[3]);
    arm_pulse();
    settle();
    for (int i = 0; i < match_rules; i++) begin
      check_hits($sformatf("rule %0d after arm", i), 8'd0, rule_hits[i]);
    end
  endtask

  initial begin
    void'($urandom(32'hf7a6_336f));
    reset       = 1'b1;
    trace_byte  = '0;
    trace_valid = 1'b0;
    arm         = 1'b0;
    fifo_full   = 1'b0;
    cfg         = '0;
    rules[0] = '{pattern: 64'h0000_a5c3, mask: 64'h0000_ffff, enable: 1'b1};
    rules[1] = '{pattern: 64'h0000_005a, mask: 64'h0000_00ff, enable: 1'b0};
    rules[2] = '{pattern: 64'h0011_22e3, mask: 64'h00ff_ffff, enable: 1'b1};
    rules[3] = '{pattern: 64'h0000_00e0, mask: 64'h0000_00f0, enable: 1'b1};
    m_cfg      = '0;
    m_buf      = '0;
    m_state    = st_idle;
    m_full     = 1'b0;
    m_overflow = 1'b0;
    m_count    = 0;
    m_trig     = 0;
    m_last_wr  = 0;
    exp_pulses = 0;
    got_base   = 0;
    pulse_base = 0;
    cyc        = 0;
    for (int i = 0; i < match_rules; i++) begin
      m_hits[i] = '0;
    end
    idle(8);
    reset <= 1'b0;
    reset_then_arm();
    raw_capture();
    match_only_capture();
    trigger_limit();
    back_pressure();
    hit_counting();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/trace_pkg.sv
source/trace_shift_buffer.sv
source/pattern_matcher.sv
source/capture_counters.sv
source/capture_fsm.sv
source/trigger_pulser.sv
source/trace_capture_top.sv
tests/trace_capture_checker.sv
tests/tb_trace_capture.sv

// ==== Makefile ====
# Verilator build and run of the trace capture testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_trace_capture -f compile.f -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
